/* include/intra_defs.svh */
// Intra mode decision engine
// Build-time sizes for block, pixels, credits and queue depths

`ifndef INTRA_DEFS_SVH
`define INTRA_DEFS_SVH

// Block edge in pixels as a power of two
`define INTRA_BLK_DIM 4

// Pixel width
`define INTRA_PIX_W 8

// Request queue depth and initial requester credits
`define INTRA_REQ_CREDITS 4

// Result channel credits and result queue depth
`define INTRA_RES_CREDITS 2
`define INTRA_RES_QDEPTH 2

`endif

/* logic/intra_pkg.sv */
// Intra mode decision types
// Pixel, row and block types, request and result payloads,
// mode encoding and per-mode header cost

`default_nettype none

`include "intra_defs.svh"

package intra_pkg;

    typedef logic [`INTRA_PIX_W-1:0] pix_t;

    // Column c of a row is element c
    typedef pix_t [`INTRA_BLK_DIM-1:0] pix_row_t;

    // Row r of a block is element r
    typedef pix_row_t [`INTRA_BLK_DIM-1:0] pix_blk_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } intra_mode_e;

    typedef struct packed {
        logic [9:0]  blk_x;
        logic [9:0]  blk_y;
        logic [15:0] lambda;
        pix_t        top_left;
        pix_row_t    top;
        pix_row_t    left;
        pix_blk_t    src;
    } intra_req_t;

    typedef struct packed {
        logic [9:0]  blk_x;
        logic [9:0]  blk_y;
        intra_mode_e mode;
        logic [31:0] score;
        pix_blk_t    pred;
    } intra_res_t;

    // Header cost indexed by mode
    localparam logic [3:0][15:0] mode_cost = {16'd919, 16'd872, 16'd919, 16'd663};

endpackage

`default_nettype wire

/* logic/credit_fifo.sv */
// Credit queue
// Circular buffer with read and write pointers and an occupancy
// count, for any packed payload type

`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* logic/intra_pred_gen.sv */
// Intra prediction generator
// Builds DC, TrueMotion, vertical and horizontal predictions
// from the edge pixels in combinational logic

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module intra_pred_gen import intra_pkg::*; (
    input  logic [9:0] blk_x,
    input  logic [9:0] blk_y,
    input  pix_t       top_left,
    input  pix_row_t   top,
    input  pix_row_t   left,
    output pix_blk_t   pred_dc,
    output pix_blk_t   pred_tm,
    output pix_blk_t   pred_ve,
    output pix_blk_t   pred_he
);

    localparam int SHIFT = $clog2(`INTRA_BLK_DIM);
    localparam int SUM_W = `INTRA_PIX_W + SHIFT + 1;

    logic                        has_top;
    logic                        has_left;
    logic [SUM_W-1:0]            sum_top;
    logic [SUM_W-1:0]            sum_left;
    logic [SUM_W-1:0]            dc_sum;
    pix_t                        dc_val;
    logic signed [`INTRA_PIX_W+1:0] tm_val;

    // Edge availability from block position
    assign has_top  = (blk_y != '0);
    assign has_left = (blk_x != '0);

    // ------------------------------------------------------------
    // DC
    // ------------------------------------------------------------
    always_comb begin
        sum_top  = '0;
        sum_left = '0;
        for (int i = 0; i < `INTRA_BLK_DIM; i++) begin
            sum_top  = sum_top + SUM_W'(top[i]);
            sum_left = sum_left + SUM_W'(left[i]);
        end
        if (has_top && has_left) begin
            dc_sum = (sum_top + sum_left + SUM_W'(`INTRA_BLK_DIM)) >> (SHIFT + 1);
        end else if (has_top) begin
            dc_sum = (sum_top + SUM_W'(`INTRA_BLK_DIM / 2)) >> SHIFT;
        end else if (has_left) begin
            dc_sum = (sum_left + SUM_W'(`INTRA_BLK_DIM / 2)) >> SHIFT;
        end else begin
            dc_sum = SUM_W'(1 << (`INTRA_PIX_W - 1));
        end
        dc_val = dc_sum[`INTRA_PIX_W-1:0];
    end

    // ------------------------------------------------------------
    // TM, VE, HE
    // ------------------------------------------------------------
    always_comb begin
        tm_val = '0;
        for (int r = 0; r < `INTRA_BLK_DIM; r++) begin
            for (int c = 0; c < `INTRA_BLK_DIM; c++) begin
                pred_dc[r][c] = dc_val;
                pred_ve[r][c] = top[c];
                pred_he[r][c] = left[r];
                tm_val = $signed({2'b00, left[r]}) + $signed({2'b00, top[c]})
                         - $signed({2'b00, top_left});
                // Clip to pixel range
                if (tm_val < 0) begin
                    pred_tm[r][c] = '0;
                end else if (tm_val > $signed({2'b00, {`INTRA_PIX_W{1'b1}}})) begin
                    pred_tm[r][c] = '1;
                end else begin
                    pred_tm[r][c] = tm_val[`INTRA_PIX_W-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/intra_mode_search.sv */
// Intra mode search
// Accumulates the SSE of each candidate one row per cycle in the
// order HE, VE, TM, DC, scores it and keeps the best mode

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module intra_mode_search import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_avail,
    input  intra_req_t req,
    output logic       req_pop,
    output intra_req_t cur_req,
    input  pix_blk_t   pred_dc,
    input  pix_blk_t   pred_tm,
    input  pix_blk_t   pred_ve,
    input  pix_blk_t   pred_he,
    input  logic       res_full,
    output logic       res_push,
    output intra_res_t res
);

    localparam int ROW_W = (`INTRA_BLK_DIM > 1) ? $clog2(`INTRA_BLK_DIM) : 1;
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`INTRA_BLK_DIM - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACC,
        S_CMP,
        S_PUSH
    } state_e;

    state_e      state;
    logic [ROW_W-1:0] row_cnt;
    intra_mode_e cur_mode;

    pix_blk_t    cand;
    logic signed [`INTRA_PIX_W:0] diff;
    logic [2*`INTRA_PIX_W-1:0] sq;
    logic [31:0] row_sse;
    logic [31:0] sse;
    logic [31:0] score;
    logic [31:0] best_score;
    intra_mode_e best_mode;
    pix_blk_t    best_pred;

    assign req_pop  = (state == S_IDLE) && req_avail;
    assign res_push = (state == S_PUSH) && !res_full;

    // ------------------------------------------------------------
    // Candidate row error and score
    // ------------------------------------------------------------
    always_comb begin
        case (cur_mode)
            MODE_DC: cand = pred_dc;
            MODE_TM: cand = pred_tm;
            MODE_VE: cand = pred_ve;
            default: cand = pred_he;
        endcase
        row_sse = '0;
        diff    = '0;
        sq      = '0;
        for (int c = 0; c < `INTRA_BLK_DIM; c++) begin
            diff    = $signed({1'b0, cur_req.src[row_cnt][c]})
                      - $signed({1'b0, cand[row_cnt][c]});
            sq      = (2*`INTRA_PIX_W)'(diff * diff);
            row_sse = row_sse + 32'(sq);
        end
    end

    assign score = (sse << 8) + 32'(cur_req.lambda) * 32'(mode_cost[cur_mode]);

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            row_cnt  <= '0;
            cur_mode <= MODE_HE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_pop) begin
                        state    <= S_ACC;
                        row_cnt  <= '0;
                        cur_mode <= MODE_HE;
                    end
                end
                S_ACC: begin
                    if (row_cnt == LAST_ROW) begin
                        row_cnt <= '0;
                        state   <= S_CMP;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                S_CMP: begin
                    if (cur_mode == MODE_DC) begin
                        state <= S_PUSH;
                    end else begin
                        cur_mode <= intra_mode_e'(cur_mode - 1'b1);
                        state    <= S_ACC;
                    end
                end
                S_PUSH: begin
                    // Hold the result while the output queue is full
                    if (res_push) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Datapath where later modes win ties
    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur_req    <= req;
            sse        <= '0;
            best_score <= '1;
        end
        if (state == S_ACC) begin
            sse <= sse + row_sse;
        end
        if (state == S_CMP) begin
            sse <= '0;
            if (score <= best_score) begin
                best_score <= score;
                best_mode  <= cur_mode;
                best_pred  <= cand;
            end
        end
    end

    assign res = '{blk_x: cur_req.blk_x, blk_y: cur_req.blk_y, mode: best_mode,
                   score: best_score, pred: best_pred};

endmodule

`default_nettype wire

/* logic/intra_result_tx.sv */
// Intra result sender
// Queues results and sends them while send credits remain

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module intra_result_tx import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  intra_res_t push_data,
    output logic       full,
    input  logic       res_credit,
    output logic       res_valid,
    output intra_res_t res
);

    localparam int CNT_W = $clog2(`INTRA_RES_CREDITS + 1);

    logic             fifo_not_empty;
    logic             send;
    logic [CNT_W-1:0] credit_cnt;

    credit_fifo #(
        .payload_t (intra_res_t),
        .DEPTH     (`INTRA_RES_QDEPTH)
    ) u_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (send),
        .head      (res),
        .not_empty (fifo_not_empty),
        .full      (full)
    );

    assign send      = fifo_not_empty && (credit_cnt != '0);
    assign res_valid = send;

    // Send credit counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(`INTRA_RES_CREDITS);
        end else begin
            case ({send, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/intra_pick_best.sv */
// Intra pick-best top level
// Request queue, prediction generator, mode search and result
// sender with credit flow control on both channels

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module intra_pick_best import intra_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  intra_req_t req,
    output logic       req_credit,
    output logic       res_valid,
    output intra_res_t res,
    input  logic       res_credit
);

    logic       req_avail;
    intra_req_t req_head;
    intra_req_t cur_req;
    pix_blk_t   pred_dc;
    pix_blk_t   pred_tm;
    pix_blk_t   pred_ve;
    pix_blk_t   pred_he;
    logic       res_push;
    logic       res_full;
    intra_res_t res_data;

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------
    credit_fifo #(
        .payload_t (intra_req_t),
        .DEPTH     (`INTRA_REQ_CREDITS)
    ) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (req_valid),
        .push_data (req),
        .pop       (req_credit),
        .head      (req_head),
        .not_empty (req_avail),
        .full      ()
    );

    // ------------------------------------------------------------
    // Processing
    // ------------------------------------------------------------
    intra_pred_gen u_pred_gen (
        .blk_x    (cur_req.blk_x),
        .blk_y    (cur_req.blk_y),
        .top_left (cur_req.top_left),
        .top      (cur_req.top),
        .left     (cur_req.left),
        .pred_dc  (pred_dc),
        .pred_tm  (pred_tm),
        .pred_ve  (pred_ve),
        .pred_he  (pred_he)
    );

    // Each pop returns one request credit
    intra_mode_search u_mode_search (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_avail (req_avail),
        .req       (req_head),
        .req_pop   (req_credit),
        .cur_req   (cur_req),
        .pred_dc   (pred_dc),
        .pred_tm   (pred_tm),
        .pred_ve   (pred_ve),
        .pred_he   (pred_he),
        .res_full  (res_full),
        .res_push  (res_push),
        .res       (res_data)
    );

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------
    intra_result_tx u_result_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (res_push),
        .push_data  (res_data),
        .full       (res_full),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

`default_nettype wire

/* verif/intra_pick_best_chk.sv */
// Credit protocol checker for the result sender
// No send without credit, counter bound, no push into a full queue

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module intra_pick_best_chk #(
    parameter int CNT_W = $clog2(`INTRA_RES_CREDITS + 1)
) (
    input logic             clk,
    input logic             rst_n,
    input logic             push,
    input logic             res_valid,
    input logic             res_credit,
    input logic [CNT_W-1:0] credit_cnt
);

    int credits_left;
    int queue_fill;

    // Credits and queue fill as seen on the port pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_left <= `INTRA_RES_CREDITS;
            queue_fill   <= 0;
        end else begin
            credits_left <= credits_left - int'(res_valid) + int'(res_credit);
            queue_fill   <= queue_fill + int'(push) - int'(res_valid);
        end
    end

    a_send_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n) res_valid |-> (credits_left > 0)
    ) else $error("result sent with no send credit left");

    // Counter never climbs past its reset value
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) credit_cnt <= CNT_W'(`INTRA_RES_CREDITS)
    ) else $error("send credit counter above its limit");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> (queue_fill < `INTRA_RES_QDEPTH)
    ) else $error("push into a full result queue");

endmodule

`default_nettype wire

/* verif/tb_intra_pick_best.sv */
// Testbench for the intra pick-best engine
// Table-driven requests with credit flow on both channels,
// checked against a reference model of the mode decision

`timescale 1ns/1ns
`default_nettype none

`include "intra_defs.svh"

module tb_intra_pick_best import intra_pkg::*; ();

    localparam int BLK          = `INTRA_BLK_DIM;
    localparam int N_STIM       = 10;
    localparam int STALL_CYCLES = 150;
    localparam int WATCHDOG_NS  = 2 * N_STIM * (25 + STALL_CYCLES) * 8 + 2000;
    localparam int SEED         = 98073;

    // Source pattern codes
    localparam logic [2:0] PAT_FLAT = 3'd0;
    localparam logic [2:0] PAT_TOP  = 3'd1;
    localparam logic [2:0] PAT_LEFT = 3'd2;
    localparam logic [2:0] PAT_TM   = 3'd3;
    localparam logic [2:0] PAT_RAND = 3'd4;

    // BY_MODEL leaves the expected mode to the reference model
    localparam logic [2:0] EXP_DC   = 3'd0;
    localparam logic [2:0] EXP_TM   = 3'd1;
    localparam logic [2:0] EXP_VE   = 3'd2;
    localparam logic [2:0] EXP_HE   = 3'd3;
    localparam logic [2:0] BY_MODEL = 3'd4;

    localparam int HDR_COST [4] = '{663, 919, 872, 919};

    typedef struct packed {
        logic [9:0]  blk_x;
        logic [9:0]  blk_y;
        logic [15:0] lambda;
        pix_t        top_left;
        pix_row_t    top;
        pix_row_t    left;
        logic [2:0]  pat;
        logic [2:0]  exp_mode;
    } stim_t;

    typedef pix_blk_t [3:0] pred_set_t;
    typedef logic [$bits(pix_blk_t)-1:0] chk_t;

    // Column 0 of an edge is its low byte
    localparam stim_t STIM [N_STIM] = '{
        '{10'd0, 10'd0, 16'd20,  8'h30, 32'h1e5a963c, 32'h28649fc8, PAT_FLAT, EXP_DC},
        '{10'd2, 10'd3, 16'd30,  8'h40, 32'hd2329664, 32'h3c786e50, PAT_TOP,  EXP_VE},
        '{10'd1, 10'd1, 16'd40,  8'h70, 32'h2878c8a0, 32'hb4326e14, PAT_LEFT, EXP_HE},
        '{10'd4, 10'd5, 16'd10,  8'h14, 32'hd2965a1e, 32'ha0785028, PAT_TM,   EXP_TM},
        '{10'd7, 10'd2, 16'd5,   8'h10, 32'hf0c8a078, 32'he6b48c64, PAT_TM,   BY_MODEL},
        '{10'd0, 10'd0, 16'd100, 8'h80, 32'h40608090, 32'h7080a0b0, PAT_RAND, BY_MODEL},
        '{10'd3, 10'd0, 16'd60,  8'h55, 32'h10305070, 32'h90b0d0f0, PAT_RAND, BY_MODEL},
        '{10'd0, 10'd6, 16'd60,  8'haa, 32'hf0d0b090, 32'h70503010, PAT_RAND, BY_MODEL},
        '{10'd5, 10'd5, 16'd0,   8'h64, 32'h64646464, 32'h64646464, PAT_RAND, EXP_DC},
        '{10'd9, 10'd9, 16'd0,   8'h50, 32'hc8643296, 32'h50505050, PAT_RAND, BY_MODEL}
    };

    logic       clk = 1'b0;
    logic       rst_n;
    logic       req_valid;
    intra_req_t req;
    logic       req_credit;
    logic       res_valid;
    intra_res_t res;
    logic       res_credit;

    intra_res_t exp_q [$];
    integer     seed;
    int         req_cred;
    int         owed;
    int         res_count;
    int         next_idx;

    intra_pick_best i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    bind intra_result_tx intra_pick_best_chk i_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .credit_cnt (credit_cnt)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic pred_set_t predict(input intra_req_t q);
        pred_set_t p;
        int        sum_t;
        int        sum_l;
        int        dc;
        int        tm;
        sum_t = 0;
        sum_l = 0;
        for (int i = 0; i < BLK; i++) begin
            sum_t += int'(q.top[i]);
            sum_l += int'(q.left[i]);
        end
        if (q.blk_x != 0 && q.blk_y != 0) begin
            dc = (sum_t + sum_l + BLK) / (2 * BLK);
        end else if (q.blk_y != 0) begin
            dc = (sum_t + BLK / 2) / BLK;
        end else if (q.blk_x != 0) begin
            dc = (sum_l + BLK / 2) / BLK;
        end else begin
            dc = 128;
        end
        for (int row = 0; row < BLK; row++) begin
            for (int col = 0; col < BLK; col++) begin
                tm = int'(q.left[row]) + int'(q.top[col]) - int'(q.top_left);
                if (tm < 0) tm = 0;
                if (tm > 255) tm = 255;
                p[0][row][col] = pix_t'(dc);
                p[1][row][col] = pix_t'(tm);
                p[2][row][col] = q.top[col];
                p[3][row][col] = q.left[row];
            end
        end
        return p;
    endfunction

    function automatic logic [31:0] score_of(input intra_req_t q, input pix_blk_t b,
                                             input int k);
        longint sse;
        longint d;
        sse = 0;
        for (int row = 0; row < BLK; row++) begin
            for (int col = 0; col < BLK; col++) begin
                d = longint'(q.src[row][col]) - longint'(b[row][col]);
                sse += d * d;
            end
        end
        return 32'(sse * 256 + longint'(q.lambda) * longint'(HDR_COST[k]));
    endfunction

    function automatic intra_res_t expect_result(input intra_req_t q,
                                                 input logic [2:0] tab_mode);
        pred_set_t   p;
        logic [2:0]  m;
        logic [31:0] s;
        logic [31:0] best_s;
        intra_res_t  e;
        p = predict(q);
        m = tab_mode;
        if (tab_mode == BY_MODEL) begin
            best_s = score_of(q, p[0], 0);
            m      = 3'd0;
            for (int k = 1; k < 4; k++) begin
                s = score_of(q, p[k], k);
                // Strict compare keeps the lower index on a tie
                if (s < best_s) begin
                    best_s = s;
                    m      = 3'(k);
                end
            end
        end
        e.blk_x = q.blk_x;
        e.blk_y = q.blk_y;
        e.mode  = intra_mode_e'(m[1:0]);
        e.score = score_of(q, p[m[1:0]], int'(m[1:0]));
        e.pred  = p[m[1:0]];
        return e;
    endfunction

    // ------------------------------------------------------------
    // Checks and stimulus
    // ------------------------------------------------------------
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic check_value(input chk_t got, input chk_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[ERROR] %0t ns: %s, got %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic build_req(input int idx, output intra_req_t q);
        stim_t     s;
        pred_set_t p;
        s          = STIM[idx];
        q          = '0;
        q.blk_x    = s.blk_x;
        q.blk_y    = s.blk_y;
        q.lambda   = s.lambda;
        q.top_left = s.top_left;
        q.top      = s.top;
        q.left     = s.left;
        for (int row = 0; row < BLK; row++) begin
            for (int col = 0; col < BLK; col++) begin
                case (s.pat)
                    PAT_FLAT: q.src[row][col] = pix_t'(128);
                    PAT_TOP:  q.src[row][col] = s.top[col];
                    PAT_LEFT: q.src[row][col] = s.left[row];
                    PAT_TM:   q.src[row][col] = '0;
                    default:  q.src[row][col] = pix_t'($random(seed));
                endcase
            end
        end
        if (s.pat == PAT_TM) begin
            p     = predict(q);
            q.src = p[1];
        end
    endtask

    task automatic take_result();
        intra_res_t e;
        if (exp_q.size() == 0) begin
            stop_run("A result arrived with no request outstanding");
        end
        e = exp_q.pop_front();
        check_value(chk_t'(res.blk_x), chk_t'(e.blk_x), "result blk_x");
        check_value(chk_t'(res.blk_y), chk_t'(e.blk_y), "result blk_y");
        check_value(chk_t'(res.mode), chk_t'(e.mode), "result mode");
        check_value(chk_t'(res.score), chk_t'(e.score), "result score");
        check_value(chk_t'(res.pred), chk_t'(e.pred), "result prediction");
        owed++;
        res_count++;
    endtask

    // One clock of the requester and the consumer
    task automatic cycle_step(input bit return_credits);
        intra_req_t q;
        @(negedge clk);
        if (req_credit) req_cred++;
        if (res_valid) take_result();
        req_valid  = 1'b0;
        res_credit = 1'b0;
        if (next_idx < N_STIM && req_cred > 0) begin
            build_req(next_idx, q);
            exp_q.push_back(expect_result(q, STIM[next_idx].exp_mode));
            req       = q;
            req_valid = 1'b1;
            req_cred--;
            next_idx++;
        end
        if (return_credits && owed > 0) begin
            res_credit = 1'b1;
            owed--;
        end
    endtask

    task automatic run_pass(input bit withhold);
        next_idx  = 0;
        res_count = 0;
        if (withhold) begin
            repeat (STALL_CYCLES) cycle_step(1'b0);
            check_value(chk_t'(res_count), chk_t'(`INTRA_RES_CREDITS),
                        "results with credits withheld");
        end
        while (next_idx < N_STIM || exp_q.size() != 0 || owed != 0) begin
            cycle_step(1'b1);
        end
        check_value(chk_t'(req_cred), chk_t'(`INTRA_REQ_CREDITS), "requester credits");
    endtask

    initial begin : main
        seed       = SEED;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        res_credit = 1'b0;
        req_cred   = `INTRA_REQ_CREDITS;
        owed       = 0;
        res_count  = 0;
        next_idx   = N_STIM;
        // Quiet outputs in reset and just after
        for (int i = 0; i < 15; i++) begin
            @(negedge clk);
            check_value(chk_t'(res_valid), chk_t'(0), "res_valid while idle");
            check_value(chk_t'(req_credit), chk_t'(0), "req_credit while idle");
            if (i == 9) rst_n = 1'b1;
        end
        run_pass(1'b0);
        run_pass(1'b1);
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_run("Timeout: results stopped arriving before all requests were answered");
    end

endmodule

`default_nettype wire

/* intra_pick_best.f */
+incdir+include
logic/intra_pkg.sv
logic/credit_fifo.sv
logic/intra_pred_gen.sv
logic/intra_mode_search.sv
logic/intra_result_tx.sv
logic/intra_pick_best.sv
verif/intra_pick_best_chk.sv
verif/tb_intra_pick_best.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the intra_pick_best testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_intra_pick_best \
    -f intra_pick_best.f \
    -o tb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim 2>&1 | tee "$LOG"
run_status=${PIPESTATUS[0]}

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Run finished, log in $LOG"
exit 0
